// File: ll_lpif_pkg.sv
////////////////////////////////////////////////////////////
// Shared link definitions for the x4 LPIF slave
// Four 40-bit lanes carry one 153-bit word per cycle
// Strobe sits at lane 0 bit 1 and marker at lane 3 bit 39
// Payload fills the lanes in order around the sync bits
////////////////////////////////////////////////////////////
`default_nettype none

package ll_lpif_pkg;

  // Lane geometry
  localparam int LL_LANES   = 4;
  localparam int LL_LANE_W  = 40;
  localparam int LL_FLAT_W  = LL_LANES * LL_LANE_W;
  localparam int LL_WORD_W  = 153;

  // Sync bit locations
  localparam int LL_STB_LANE = 0;
  localparam int LL_STB_BIT  = 1;
  localparam int LL_MRK_LANE = 3;
  localparam int LL_MRK_BIT  = 39;
  // Same locations in the flattened lane vector
  localparam int LL_STB_POS  = LL_STB_LANE * LL_LANE_W + LL_STB_BIT;
  localparam int LL_MRK_POS  = LL_MRK_LANE * LL_LANE_W + LL_MRK_BIT;
  // Unused bits between payload top and marker
  localparam int LL_SPARE_W  = LL_FLAT_W - LL_WORD_W - 2;

  // Flit field widths
  localparam int LL_DATA_W   = 128;
  localparam int LL_CRC_W    = 16;
  localparam int LL_STATE_W  = 4;
  localparam int LL_PROTID_W = 2;

  // Field offsets in the packed word, LSB first
  localparam int LL_OFF_DATA      = 0;
  localparam int LL_OFF_CRC       = LL_OFF_DATA + LL_DATA_W;
  localparam int LL_OFF_STATE     = LL_OFF_CRC + LL_CRC_W;
  localparam int LL_OFF_PROTID    = LL_OFF_STATE + LL_STATE_W;
  localparam int LL_OFF_DVALID    = LL_OFF_PROTID + LL_PROTID_W;
  localparam int LL_OFF_CRC_VALID = LL_OFF_DVALID + 1;
  localparam int LL_OFF_VALID     = LL_OFF_CRC_VALID + 1;

  typedef logic [LL_WORD_W-1:0] ll_word_t;
  typedef logic [LL_LANE_W-1:0] ll_lane_t;
  typedef logic [15:0]          ll_delay_t;
  typedef logic [31:0]          ll_dbg_t;

  // Online delay FSM states
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_COUNT,
    SYNC_ONLINE
  } ll_sync_state_e;

endpackage

`default_nettype wire

// File: ll_auto_sync.sv
////////////////////////////////////////////////////////////
// Online delay and sync bit generation
// TX goes online y+z cycles after tx_online is first sampled
// RX goes online x cycles after rx_online, zero means next edge
// DELAY_WIDTH must not exceed 16, upper delay bits are ignored
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync
  import ll_lpif_pkg::*;
#(
  parameter int DELAY_WIDTH = 16
) (
  input  logic      clk_wr,
  input  logic      rst_n,
  input  logic      tx_online,
  input  logic      rx_online,
  input  ll_delay_t delay_x_value,
  input  ll_delay_t delay_y_value,
  input  ll_delay_t delay_z_value,
  output logic      tx_online_delay,
  output logic      rx_online_delay,
  output logic      tx_stb_userbit,
  output logic      tx_mrk_userbit
);

  // One extra bit so y+z cannot wrap
  localparam int CW = DELAY_WIDTH + 1;

  // Channel 0 is TX, channel 1 is RX
  logic [1:0]     online_in;
  logic [CW-1:0]  target [2];
  logic [CW-1:0]  cnt_q [2];
  ll_sync_state_e state_q [2];

  assign online_in = {rx_online, tx_online};

  // TX waits for both y and z
  assign target[0] = CW'(delay_y_value[DELAY_WIDTH-1:0]) +
                     CW'(delay_z_value[DELAY_WIDTH-1:0]);
  assign target[1] = CW'(delay_x_value[DELAY_WIDTH-1:0]);

  ////////////////////////////////////////////////////////////
  // Delay FSMs
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      // Dropping the input always restarts the wait
      if (!rst_n || !online_in[i]) begin
        state_q[i] <= SYNC_IDLE;
        cnt_q[i]   <= '0;
      end else begin
        case (state_q[i])
          SYNC_IDLE: begin
            // First edge with input high counts as cycle one
            cnt_q[i]   <= CW'(1);
            state_q[i] <= (target[i] == '0) ? SYNC_ONLINE : SYNC_COUNT;
          end
          SYNC_COUNT: begin
            if (cnt_q[i] >= target[i]) begin
              state_q[i] <= SYNC_ONLINE;
            end else begin
              cnt_q[i] <= cnt_q[i] + 1'b1;
            end
          end
          SYNC_ONLINE: begin
            // Hold until input drops
            state_q[i] <= SYNC_ONLINE;
          end
          default: begin
            state_q[i] <= SYNC_IDLE;
          end
        endcase
      end
    end
  end

  assign tx_online_delay = (state_q[0] == SYNC_ONLINE);
  assign rx_online_delay = (state_q[1] == SYNC_ONLINE);

  // Persistent strobe and marker while TX is online
  assign tx_stb_userbit = tx_online_delay;
  assign tx_mrk_userbit = tx_online_delay;

endmodule

`default_nettype wire

// File: ll_tx_lane_map.sv
////////////////////////////////////////////////////////////
// Transmit flit packer and lane mapper
// Lanes are registered, zero while tx_online_delay is low
// No back-pressure, one word leaves every cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ll_tx_lane_map
  import ll_lpif_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  logic                   tx_online_delay,
  input  logic                   tx_stb_userbit,
  input  logic                   tx_mrk_userbit,
  input  logic [LL_STATE_W-1:0]  ustrm_state,
  input  logic [LL_PROTID_W-1:0] ustrm_protid,
  input  logic [LL_DATA_W-1:0]   ustrm_data,
  input  logic                   ustrm_dvalid,
  input  logic [LL_CRC_W-1:0]    ustrm_crc,
  input  logic                   ustrm_crc_valid,
  input  logic                   ustrm_valid,
  output ll_lane_t               tx_phy0,
  output ll_lane_t               tx_phy1,
  output ll_lane_t               tx_phy2,
  output ll_lane_t               tx_phy3,
  output ll_dbg_t                tx_upstream_debug_status
);

  ll_word_t               tx_word;
  logic [LL_FLAT_W-1:0]   tx_flat;
  logic [LL_FLAT_W-1:0]   lanes_q;
  ll_dbg_t                sent_cnt_q;

  ////////////////////////////////////////////////////////////
  // Flit packing
  ////////////////////////////////////////////////////////////
  assign tx_word[LL_OFF_DATA   +: LL_DATA_W]   = ustrm_data;
  assign tx_word[LL_OFF_CRC    +: LL_CRC_W]    = ustrm_crc;
  assign tx_word[LL_OFF_STATE  +: LL_STATE_W]  = ustrm_state;
  assign tx_word[LL_OFF_PROTID +: LL_PROTID_W] = ustrm_protid;
  assign tx_word[LL_OFF_DVALID]                = ustrm_dvalid;
  assign tx_word[LL_OFF_CRC_VALID]             = ustrm_crc_valid;
  assign tx_word[LL_OFF_VALID]                 = ustrm_valid;

  // Lane spread, LSB upward
  // Payload skips the strobe slot, spare zeros pad up to the marker
  // Marker is the very top bit of lane 3
  assign tx_flat = {tx_mrk_userbit,
                    {LL_SPARE_W{1'b0}},
                    tx_word[LL_WORD_W-1:LL_STB_POS],
                    tx_stb_userbit,
                    tx_word[LL_STB_POS-1:0]};

  ////////////////////////////////////////////////////////////
  // Lane registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      lanes_q <= '0;
    end else if (tx_online_delay) begin
      lanes_q <= tx_flat;
    end else begin
      // Idle lanes while link is offline
      lanes_q <= '0;
    end
  end

  assign tx_phy0 = lanes_q[0*LL_LANE_W +: LL_LANE_W];
  assign tx_phy1 = lanes_q[1*LL_LANE_W +: LL_LANE_W];
  assign tx_phy2 = lanes_q[2*LL_LANE_W +: LL_LANE_W];
  assign tx_phy3 = lanes_q[3*LL_LANE_W +: LL_LANE_W];

  ////////////////////////////////////////////////////////////
  // Sent word counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      sent_cnt_q <= '0;
    end else if (tx_online_delay && ustrm_valid) begin
      // Wraps at 2^32
      sent_cnt_q <= sent_cnt_q + 1'b1;
    end
  end

  assign tx_upstream_debug_status = sent_cnt_q;

endmodule

`default_nettype wire

// File: ll_rx_word_align.sv
////////////////////////////////////////////////////////////
// Receive lane register and sync check
// Word is accepted only with both strobe and marker set
// and rx_online_delay high, no realignment is attempted
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ll_rx_word_align
  import ll_lpif_pkg::*;
(
  input  logic     clk_wr,
  input  logic     rst_n,
  input  logic     rx_online_delay,
  input  ll_lane_t rx_phy0,
  input  ll_lane_t rx_phy1,
  input  ll_lane_t rx_phy2,
  input  ll_lane_t rx_phy3,
  output ll_word_t rx_word,
  output logic     rx_word_ok,
  output ll_dbg_t  rx_downstream_debug_status
);

  logic [LL_FLAT_W-1:0] lanes_q;
  logic                 stb_bit;
  logic                 mrk_bit;
  ll_dbg_t              rej_cnt_q;

  ////////////////////////////////////////////////////////////
  // Lane capture
  ////////////////////////////////////////////////////////////
  // Payload only, validity comes from rx_word_ok
  always_ff @(posedge clk_wr) begin
    lanes_q <= {rx_phy3, rx_phy2, rx_phy1, rx_phy0};
  end

  // Sync bits
  assign stb_bit = lanes_q[LL_STB_POS];
  assign mrk_bit = lanes_q[LL_MRK_POS];

  // Gather payload back around the strobe slot
  // Spare bits are dropped
  assign rx_word = {lanes_q[LL_WORD_W:LL_STB_POS+1],
                    lanes_q[LL_STB_POS-1:0]};

  // Accept check
  assign rx_word_ok = rx_online_delay && stb_bit && mrk_bit;

  ////////////////////////////////////////////////////////////
  // Rejected word counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rej_cnt_q <= '0;
    end else if (rx_online_delay && !rx_word_ok) begin
      // Only counts while online, offline words are expected junk
      rej_cnt_q <= rej_cnt_q + 1'b1;
    end
  end

  assign rx_downstream_debug_status = rej_cnt_q;

endmodule

`default_nettype wire

// File: ll_rx_unpack.sv
////////////////////////////////////////////////////////////
// Receive flit unpacker
// Outputs are registered, all zero for a rejected word
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ll_rx_unpack
  import ll_lpif_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  ll_word_t               rx_word,
  input  logic                   rx_word_ok,
  output logic [LL_STATE_W-1:0]  dstrm_state,
  output logic [LL_PROTID_W-1:0] dstrm_protid,
  output logic [LL_DATA_W-1:0]   dstrm_data,
  output logic                   dstrm_dvalid,
  output logic [LL_CRC_W-1:0]    dstrm_crc,
  output logic                   dstrm_crc_valid,
  output logic                   dstrm_valid
);

  ////////////////////////////////////////////////////////////
  // Field split
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_word_ok) begin
      // Bad or offline word shows as an empty flit
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= 1'b0;
      dstrm_valid     <= 1'b0;
    end else begin
      dstrm_state     <= rx_word[LL_OFF_STATE  +: LL_STATE_W];
      dstrm_protid    <= rx_word[LL_OFF_PROTID +: LL_PROTID_W];
      dstrm_data      <= rx_word[LL_OFF_DATA   +: LL_DATA_W];
      dstrm_dvalid    <= rx_word[LL_OFF_DVALID];
      dstrm_crc       <= rx_word[LL_OFF_CRC    +: LL_CRC_W];
      dstrm_crc_valid <= rx_word[LL_OFF_CRC_VALID];
      // Valid passes through as sent, not forced high
      dstrm_valid     <= rx_word[LL_OFF_VALID];
    end
  end

endmodule

`default_nettype wire

// File: ll_lpif_slave_top.sv
////////////////////////////////////////////////////////////
// LPIF x4 logic-link slave, single clock clk_wr
// No FIFO, no credits, no back-pressure
// Latency rx_phy to dstrm is 2 cycles, ustrm to tx_phy is 1
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ll_lpif_slave_top
  import ll_lpif_pkg::*;
#(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  ll_delay_t              delay_x_value,
  input  ll_delay_t              delay_y_value,
  input  ll_delay_t              delay_z_value,

  // PHY lanes
  output ll_lane_t               tx_phy0,
  output ll_lane_t               tx_phy1,
  output ll_lane_t               tx_phy2,
  output ll_lane_t               tx_phy3,
  input  ll_lane_t               rx_phy0,
  input  ll_lane_t               rx_phy1,
  input  ll_lane_t               rx_phy2,
  input  ll_lane_t               rx_phy3,

  // Upstream flit
  input  logic [LL_STATE_W-1:0]  ustrm_state,
  input  logic [LL_PROTID_W-1:0] ustrm_protid,
  input  logic [LL_DATA_W-1:0]   ustrm_data,
  input  logic                   ustrm_dvalid,
  input  logic [LL_CRC_W-1:0]    ustrm_crc,
  input  logic                   ustrm_crc_valid,
  input  logic                   ustrm_valid,

  // Downstream flit
  output logic [LL_STATE_W-1:0]  dstrm_state,
  output logic [LL_PROTID_W-1:0] dstrm_protid,
  output logic [LL_DATA_W-1:0]   dstrm_data,
  output logic                   dstrm_dvalid,
  output logic [LL_CRC_W-1:0]    dstrm_crc,
  output logic                   dstrm_crc_valid,
  output logic                   dstrm_valid,

  // Debug counters
  output ll_dbg_t                tx_upstream_debug_status,
  output ll_dbg_t                rx_downstream_debug_status
);

  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_stb_userbit;
  logic     tx_mrk_userbit;
  ll_word_t rx_word;
  logic     rx_word_ok;

  ////////////////////////////////////////////////////////////
  // Online delay and sync bits
  ////////////////////////////////////////////////////////////
  ll_auto_sync #(
    .DELAY_WIDTH (DELAY_WIDTH)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit)
  );

  ////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////
  ll_tx_lane_map u_tx_lane_map (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .tx_online_delay          (tx_online_delay),
    .tx_stb_userbit           (tx_stb_userbit),
    .tx_mrk_userbit           (tx_mrk_userbit),
    .ustrm_state              (ustrm_state),
    .ustrm_protid             (ustrm_protid),
    .ustrm_data               (ustrm_data),
    .ustrm_dvalid             (ustrm_dvalid),
    .ustrm_crc                (ustrm_crc),
    .ustrm_crc_valid          (ustrm_crc_valid),
    .ustrm_valid              (ustrm_valid),
    .tx_phy0                  (tx_phy0),
    .tx_phy1                  (tx_phy1),
    .tx_phy2                  (tx_phy2),
    .tx_phy3                  (tx_phy3),
    .tx_upstream_debug_status (tx_upstream_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////
  ll_rx_word_align u_rx_word_align (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .rx_online_delay            (rx_online_delay),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_phy2                    (rx_phy2),
    .rx_phy3                    (rx_phy3),
    .rx_word                    (rx_word),
    .rx_word_ok                 (rx_word_ok),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  ll_rx_unpack u_rx_unpack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

endmodule

`default_nettype wire

// File: tb_ll_lpif_slave.sv
////////////////////////////////////////////////////////////
// Testbench for the x4 LPIF logic-link slave
// TX lanes loop back to RX and the strobe can be flipped on the way
// Cycle model runs at the falling edge and assertions check it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ll_lpif_slave
  import ll_lpif_pkg::*;
;

  localparam int CLK_PERIOD = 100;
  // Cycle budget per test
  localparam int RESET_CYCLES  = 10;
  localparam int DELAY_CYCLES  = 12;
  localparam int GATE_CYCLES   = 10;
  localparam int LOOP_FLITS    = 200;
  localparam int STB_CYCLES    = 24;
  localparam int COUNT_CYCLES  = 30;
  localparam int FLUSH_CYCLES  = 5;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + DELAY_CYCLES + GATE_CYCLES + LOOP_FLITS +
                                 STB_CYCLES + COUNT_CYCLES + FLUSH_CYCLES;

  logic clk_wr, rst_n, tx_online, rx_online;
  ll_delay_t delay_x_value, delay_y_value, delay_z_value;
  ll_lane_t tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  ll_lane_t rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  logic [LL_STATE_W-1:0] ustrm_state, dstrm_state;
  logic [LL_PROTID_W-1:0] ustrm_protid, dstrm_protid;
  logic [LL_DATA_W-1:0] ustrm_data, dstrm_data;
  logic [LL_CRC_W-1:0] ustrm_crc, dstrm_crc;
  logic ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  ll_dbg_t tx_upstream_debug_status, rx_downstream_debug_status;

  // Loopback control
  logic phy_loop;
  logic inv_stb;

  logic [31:0] lcg_state;
  string       test_name;

  // Whole-bus views with the flit ordered valid down to data
  logic [159:0] lanes_out;
  logic [152:0] dstrm_out;
  assign lanes_out = {tx_phy3, tx_phy2, tx_phy1, tx_phy0};
  assign dstrm_out = {dstrm_valid, dstrm_crc_valid, dstrm_dvalid, dstrm_protid,
                      dstrm_state, dstrm_crc, dstrm_data};

  assign rx_phy0 = phy_loop ? (tx_phy0 ^ {38'b0, inv_stb, 1'b0}) : '0;
  assign rx_phy1 = phy_loop ? tx_phy1 : '0;
  assign rx_phy2 = phy_loop ? tx_phy2 : '0;
  assign rx_phy3 = phy_loop ? tx_phy3 : '0;

  // Reference model state
  logic [152:0] tx_flit_m, rx_flit_m, exp_dstrm;
  logic         tx_sync_m, rx_sync_m, tx_del_m, rx_del_m;
  logic [159:0] exp_tx_flat;
  ll_dbg_t      exp_sent, exp_rej;
  int           tx_seen, rx_seen;

  ll_lpif_slave_top #(
    .DELAY_WIDTH (16)
  ) DUT (
    .clk_wr (clk_wr), .rst_n (rst_n), .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1), .tx_phy2 (tx_phy2), .tx_phy3 (tx_phy3),
    .rx_phy0 (rx_phy0), .rx_phy1 (rx_phy1), .rx_phy2 (rx_phy2), .rx_phy3 (rx_phy3),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .tx_upstream_debug_status (tx_upstream_debug_status),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Payload fills bits upward, skipping strobe slot 1 and marker slot 159
  function automatic logic [159:0] spread_lanes(logic [152:0] w, logic sync);
    logic [159:0] f;
    int           j;
    f = '0;
    j = 0;
    for (int i = 0; i < 160; i++) begin
      if (i == 1 || i == 159) begin
        f[i] = sync;
      end else if (j < 153) begin
        f[i] = w[j];
        j++;
      end
    end
    return f;
  endfunction

  task automatic report_mismatch(string check, logic [159:0] exp_v, logic [159:0] act_v);
    $display("CHECK FAILED test=%s check=%s expected=%h actual=%h",
             test_name, check, exp_v, act_v);
    $display("SOME TESTS FAILED");
    $fatal(1, "Mismatch on %s", check);
  endtask

  task automatic drive_random_flit();
    logic [31:0] r;
    ustrm_data[31:0]   = lcg_next();
    ustrm_data[63:32]  = lcg_next();
    ustrm_data[95:64]  = lcg_next();
    ustrm_data[127:96] = lcg_next();
    r = lcg_next();
    ustrm_crc       = r[31:16];
    ustrm_state     = r[15:12];
    ustrm_protid    = r[11:10];
    ustrm_dvalid    = r[9];
    ustrm_crc_valid = r[8];
    // Mostly valid with some idle flits
    ustrm_valid     = r[7] | r[6];
  endtask

  // Account for the rising edge just passed while inputs still hold its values
  task automatic update_model();
    logic [152:0] flit_in;
    logic         tx_del_old;
    logic         rx_del_old;
    flit_in = {ustrm_valid, ustrm_crc_valid, ustrm_dvalid, ustrm_protid, ustrm_state,
               ustrm_crc, ustrm_data};
    tx_del_old = tx_del_m;
    rx_del_old = rx_del_m;
    if (!rst_n) begin
      {tx_flit_m, rx_flit_m, exp_dstrm} = '0;
      {tx_sync_m, rx_sync_m, tx_del_m, rx_del_m} = '0;
      exp_tx_flat = '0;
      exp_sent = '0;
      exp_rej = '0;
      tx_seen = 0;
      rx_seen = 0;
    end else begin
      // Unpack stage sees the word captured one edge earlier
      exp_dstrm = (rx_del_old && rx_sync_m) ? rx_flit_m : '0;
      if (rx_del_old && !rx_sync_m) exp_rej = exp_rej + 1'b1;
      // Flipped strobe fails the check while the marker still follows TX
      rx_flit_m = tx_flit_m;
      rx_sync_m = tx_sync_m && !inv_stb;
      tx_flit_m = tx_del_old ? flit_in : '0;
      tx_sync_m = tx_del_old;
      exp_tx_flat = tx_del_old ? spread_lanes(flit_in, 1'b1) : '0;
      if (tx_del_old && ustrm_valid) exp_sent = exp_sent + 1'b1;
      // Delayed online once enough high edges were seen
      tx_seen = tx_online ? tx_seen + 1 : 0;
      rx_seen = rx_online ? rx_seen + 1 : 0;
      tx_del_m = tx_seen > (int'(delay_y_value) + int'(delay_z_value));
      rx_del_m = rx_seen > int'(delay_x_value);
    end
  endtask

  task automatic next_cycle();
    @(negedge clk_wr);
    update_model();
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  tx_lanes_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    lanes_out == exp_tx_flat)
    else report_mismatch("tx_lanes", $sampled(exp_tx_flat), $sampled(lanes_out));

  dstrm_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    dstrm_out == exp_dstrm)
    else report_mismatch("dstrm", 160'($sampled(exp_dstrm)), 160'($sampled(dstrm_out)));

  sent_count_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_upstream_debug_status == exp_sent)
    else report_mismatch("tx_count", 160'($sampled(exp_sent)),
                         160'($sampled(tx_upstream_debug_status)));

  reject_count_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_downstream_debug_status == exp_rej)
    else report_mismatch("rx_reject_count", 160'($sampled(exp_rej)),
                         160'($sampled(rx_downstream_debug_status)));

  ////////////////////////////////////////////////////////////
  // Clock, watchdog, stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  initial begin
    #((TOTAL_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired, stimulus did not finish within %0d cycles", TOTAL_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    lcg_state = 32'd98864;
    test_name = "reset";
    {rst_n, tx_online, rx_online, phy_loop, inv_stb} = '0;
    delay_x_value = 16'd4;
    delay_y_value = 16'd3;
    delay_z_value = 16'd2;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_crc} = '0;
    {ustrm_dvalid, ustrm_crc_valid, ustrm_valid} = '0;
    // First rising edge starts the reset count
    @(posedge clk_wr);
    repeat (RESET_CYCLES) next_cycle();
    rst_n = 1'b1;
    phy_loop = 1'b1;

    // Lanes idle through y+z with RX still offline
    test_name = "online_delay";
    tx_online = 1'b1;
    repeat (DELAY_CYCLES) begin
      drive_random_flit();
      next_cycle();
    end

    // dstrm stays empty until the x delay expires
    test_name = "rx_gating";
    rx_online = 1'b1;
    repeat (GATE_CYCLES) begin
      drive_random_flit();
      next_cycle();
    end

    test_name = "loopback";
    repeat (LOOP_FLITS) begin
      drive_random_flit();
      next_cycle();
    end

    // Every third word gets a bad strobe
    test_name = "strobe_error";
    for (int i = 0; i < STB_CYCLES; i++) begin
      drive_random_flit();
      inv_stb = (i % 3 == 0);
      next_cycle();
    end
    inv_stb = 1'b0;

    // Valid flits while TX is down must not count
    test_name = "tx_count";
    for (int i = 0; i < COUNT_CYCLES; i++) begin
      drive_random_flit();
      tx_online = !(i >= 2 && i < 8);
      rx_online = !(i >= 20 && i < 26);
      next_cycle();
    end

    test_name = "flush";
    {ustrm_dvalid, ustrm_crc_valid, ustrm_valid} = '0;
    repeat (FLUSH_CYCLES) next_cycle();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
ll_lpif_pkg.sv
ll_auto_sync.sv
ll_tx_lane_map.sv
ll_rx_word_align.sv
ll_rx_unpack.sv
ll_lpif_slave_top.sv
tb_ll_lpif_slave.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_ll_lpif_slave
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build and run, a $fatal in the run gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
